// ==== common/lsu_pkg.sv ====
// Shared types and constants for the load/store unit.
// Holds the bus widths, access width and AXI response codes, the
// command, request and response records, the AXI4-Lite channel
// payloads and the default address windows.

package lsu_pkg;

    // ====================
    // widths
    localparam int addr_w = 32;
    localparam int data_w = 64;
    localparam int strb_w = data_w / 8;

    // encoding matches the AXI size code
    typedef enum logic [1:0] {
        mem_byte  = 2'd0,
        mem_half  = 2'd1,
        mem_word  = 2'd2,
        mem_dword = 2'd3
    } mem_width_e;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_e;

    // ====================
    // pipeline side
    typedef struct packed {
        logic              store;
        mem_width_e        width;
        logic              is_unsigned;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } lsu_cmd_t;

    // decoded, waiting in the command queue
    typedef struct packed {
        logic              store;
        mem_width_e        width;
        logic              is_unsigned;
        logic              unmapped;
        logic [addr_w-1:0] addr;
        logic [2:0]        lane;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] strb;
    } lsu_req_t;

    typedef struct packed {
        logic              store;
        logic              error;
        logic [data_w-1:0] data;
    } lsu_rsp_t;

    // ====================
    // AXI4-Lite payloads
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [2:0]        prot;
    } axi_addr_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
    } axi_wdata_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        axi_resp_e         resp;
    } axi_rdata_t;

    // default windows, end is exclusive
    localparam logic [addr_w-1:0] mem_base_default  = 32'h8000_0000;
    localparam logic [addr_w-1:0] mem_end_default   = 32'h8800_0000;
    localparam logic [addr_w-1:0] mmio_base_default = 32'h1000_0000;
    localparam logic [addr_w-1:0] mmio_end_default  = 32'h2000_0000;

endpackage

// ==== hdl/lsu_cmd_decode.sv ====
// Command decoder for the load/store unit.
// Checks the address against the memory and MMIO windows, aligns it to
// the dword, and builds the byte strobe and lane-shifted write data.
// Purely combinational.

module lsu_cmd_decode #(
    parameter logic [lsu_pkg::addr_w-1:0] MEM_BASE  = lsu_pkg::mem_base_default,
    parameter logic [lsu_pkg::addr_w-1:0] MEM_END   = lsu_pkg::mem_end_default,
    parameter logic [lsu_pkg::addr_w-1:0] MMIO_BASE = lsu_pkg::mmio_base_default,
    parameter logic [lsu_pkg::addr_w-1:0] MMIO_END  = lsu_pkg::mmio_end_default
) (
    input  lsu_pkg::lsu_cmd_t cmd,
    output lsu_pkg::lsu_req_t req
);

    logic                        in_mem;
    logic                        in_mmio;
    logic [2:0]                  lane;
    logic [lsu_pkg::strb_w-1:0]  width_mask;

    // ====================
    // region check
    assign in_mem  = (cmd.addr >= MEM_BASE) && (cmd.addr < MEM_END);
    assign in_mmio = (cmd.addr >= MMIO_BASE) && (cmd.addr < MMIO_END);

    assign lane = cmd.addr[2:0];

    // ones for each byte the access covers
    always_comb begin
        case (cmd.width)
            lsu_pkg::mem_byte: begin
                width_mask = 8'b0000_0001;
            end
            lsu_pkg::mem_half: begin
                width_mask = 8'b0000_0011;
            end
            lsu_pkg::mem_word: begin
                width_mask = 8'b0000_1111;
            end
            default: begin
                width_mask = 8'b1111_1111;
            end
        endcase
    end

    // ====================
    // request fields
    always_comb begin
        req             = '0;
        req.store       = cmd.store;
        req.width       = cmd.width;
        req.is_unsigned = cmd.is_unsigned;
        req.unmapped    = !(in_mem || in_mmio);
        req.addr        = {cmd.addr[lsu_pkg::addr_w-1:3], 3'b000};
        req.lane        = lane;
        // move the store data up to its byte lanes
        req.wdata       = cmd.wdata << {lane, 3'b000};
        req.strb        = width_mask << lane;
    end

endmodule

// ==== hdl/lsu_queue.sv ====
// Synchronous FIFO for any packed payload.
// Circular buffer with read and write pointers and an occupancy
// count. Push and pop may happen in the same cycle.

module lsu_queue #(
    parameter int  DEPTH     = 2,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push_valid,
    output logic     push_ready,
    input  payload_t push_data,
    output logic     pop_valid,
    input  logic     pop_ready,
    output payload_t pop_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t             mem [DEPTH];
    logic     [PTR_W-1:0] wr_ptr;
    logic     [PTR_W-1:0] rd_ptr;
    logic     [CNT_W-1:0] count;
    logic                 push;
    logic                 pop;

    assign push_ready = (count != CNT_W'(DEPTH));
    assign pop_valid  = (count != '0);
    assign push       = push_valid && push_ready;
    assign pop        = pop_valid && pop_ready;
    assign pop_data   = mem[rd_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers and count, wrap at DEPTH
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== axi_master/lsu_axi_master.sv ====
// AXI4-Lite master of the load/store unit.
// Pops one decoded request at a time, runs a single read or write on
// the bus and pushes the result. Unmapped requests get an error result
// straight away. Load data is moved down from its lane and extended by
// width and signedness.

module lsu_axi_master (
    input  logic                clk,
    input  logic                rst,
    // request queue head
    input  logic                req_valid,
    output logic                req_ready,
    input  lsu_pkg::lsu_req_t   req,
    // response queue push side
    output logic                rsp_valid,
    input  logic                rsp_full,
    output lsu_pkg::lsu_rsp_t   rsp,
    // AXI4-Lite
    output logic                awvalid,
    input  logic                awready,
    output lsu_pkg::axi_addr_t  aw,
    output logic                wvalid,
    input  logic                wready,
    output lsu_pkg::axi_wdata_t w,
    input  logic                bvalid,
    output logic                bready,
    input  lsu_pkg::axi_resp_e  bresp,
    output logic                arvalid,
    input  logic                arready,
    output lsu_pkg::axi_addr_t  ar,
    input  logic                rvalid,
    output logic                rready,
    input  lsu_pkg::axi_rdata_t r
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_resp
    } state_e;

    state_e                       state;
    state_e                       state_next;
    lsu_pkg::lsu_req_t            req_q;
    logic                         pop;
    logic                         aw_ok;
    logic                         w_ok;
    logic [lsu_pkg::data_w-1:0]   lane_data;
    logic [lsu_pkg::data_w-1:0]   load_data;

    // ====================
    // control
    assign req_ready = (state == st_idle) && !rsp_full;
    assign pop       = req_valid && req_ready;

    // each write channel is done once its valid has dropped or handshakes now
    assign aw_ok = !awvalid || awready;
    assign w_ok  = !wvalid || wready;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (pop && !req.unmapped) begin
                    state_next = st_addr;
                end
            end
            st_addr: begin
                if (req_q.store) begin
                    if (aw_ok && w_ok) begin
                        state_next = st_resp;
                    end
                end else if (arready) begin
                    state_next = st_resp;
                end
            end
            st_resp: begin
                if (req_q.store ? bvalid : rvalid) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            req_q <= req;
        end
    end

    // valids rise at the pop edge, drop on their own handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
        end else if (pop && !req.unmapped) begin
            awvalid <= req.store;
            wvalid  <= req.store;
            arvalid <= !req.store;
        end else begin
            if (awready) begin
                awvalid <= 1'b0;
            end
            if (wready) begin
                wvalid <= 1'b0;
            end
            if (arready) begin
                arvalid <= 1'b0;
            end
        end
    end

    assign bready = (state == st_resp) && req_q.store;
    assign rready = (state == st_resp) && !req_q.store;

    // ====================
    // bus payloads
    assign aw = '{addr: req_q.addr, prot: 3'b000};
    assign ar = '{addr: req_q.addr, prot: 3'b000};
    assign w  = '{data: req_q.wdata, strb: req_q.strb};

    // ====================
    // load data
    assign lane_data = r.data >> {req_q.lane, 3'b000};

    always_comb begin
        case (req_q.width)
            lsu_pkg::mem_byte: begin
                load_data = {{(lsu_pkg::data_w - 8){!req_q.is_unsigned && lane_data[7]}},
                             lane_data[7:0]};
            end
            lsu_pkg::mem_half: begin
                load_data = {{(lsu_pkg::data_w - 16){!req_q.is_unsigned && lane_data[15]}},
                             lane_data[15:0]};
            end
            lsu_pkg::mem_word: begin
                load_data = {{(lsu_pkg::data_w - 32){!req_q.is_unsigned && lane_data[31]}},
                             lane_data[31:0]};
            end
            default: begin
                load_data = lane_data;
            end
        endcase
    end

    // ====================
    // response
    assign rsp_valid = (pop && req.unmapped) || (bvalid && bready) || (rvalid && rready);

    always_comb begin
        rsp = '0;
        if (state == st_idle) begin
            // only pushed for an unmapped request
            rsp.store = req.store;
            rsp.error = 1'b1;
        end else if (req_q.store) begin
            rsp.store = 1'b1;
            rsp.error = (bresp != lsu_pkg::resp_okay);
        end else begin
            rsp.error = (r.resp != lsu_pkg::resp_okay);
            rsp.data  = rsp.error ? '0 : load_data;
        end
    end

endmodule

// ==== hdl/lsu_top.sv ====
// Load/store unit top level.
// Decodes pipeline commands into a command queue, runs them one at a
// time as an AXI4-Lite master and returns results in command order
// through a response queue.

module lsu_top #(
    parameter logic [lsu_pkg::addr_w-1:0] MEM_BASE  = lsu_pkg::mem_base_default,
    parameter logic [lsu_pkg::addr_w-1:0] MEM_END   = lsu_pkg::mem_end_default,
    parameter logic [lsu_pkg::addr_w-1:0] MMIO_BASE = lsu_pkg::mmio_base_default,
    parameter logic [lsu_pkg::addr_w-1:0] MMIO_END  = lsu_pkg::mmio_end_default,
    parameter int                         CMD_DEPTH = 2,
    parameter int                         RSP_DEPTH = 2
) (
    input  logic                clk,
    input  logic                rst,
    // command port
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  lsu_pkg::lsu_cmd_t   cmd,
    // response port
    output logic                rsp_valid,
    input  logic                rsp_ready,
    output lsu_pkg::lsu_rsp_t   rsp,
    // AXI4-Lite master
    output logic                awvalid,
    input  logic                awready,
    output lsu_pkg::axi_addr_t  aw,
    output logic                wvalid,
    input  logic                wready,
    output lsu_pkg::axi_wdata_t w,
    input  logic                bvalid,
    output logic                bready,
    input  lsu_pkg::axi_resp_e  bresp,
    output logic                arvalid,
    input  logic                arready,
    output lsu_pkg::axi_addr_t  ar,
    input  logic                rvalid,
    output logic                rready,
    input  lsu_pkg::axi_rdata_t r
);

    lsu_pkg::lsu_req_t dec_req;
    lsu_pkg::lsu_req_t head_req;
    logic              head_valid;
    logic              head_ready;
    lsu_pkg::lsu_rsp_t mst_rsp;
    logic              mst_rsp_valid;
    logic              rsp_push_ready;
    logic              rsp_full;

    assign rsp_full = !rsp_push_ready;

    lsu_cmd_decode #(
        .MEM_BASE  (MEM_BASE),
        .MEM_END   (MEM_END),
        .MMIO_BASE (MMIO_BASE),
        .MMIO_END  (MMIO_END)
    ) i_decode (
        .cmd (cmd),
        .req (dec_req)
    );

    // ====================
    // command queue
    lsu_queue #(
        .DEPTH     (CMD_DEPTH),
        .payload_t (lsu_pkg::lsu_req_t)
    ) i_cmd_queue (
        .clk        (clk),
        .rst        (rst),
        .push_valid (cmd_valid),
        .push_ready (cmd_ready),
        .push_data  (dec_req),
        .pop_valid  (head_valid),
        .pop_ready  (head_ready),
        .pop_data   (head_req)
    );

    lsu_axi_master i_master (
        .clk       (clk),
        .rst       (rst),
        .req_valid (head_valid),
        .req_ready (head_ready),
        .req       (head_req),
        .rsp_valid (mst_rsp_valid),
        .rsp_full  (rsp_full),
        .rsp       (mst_rsp),
        .awvalid   (awvalid),
        .awready   (awready),
        .aw        (aw),
        .wvalid    (wvalid),
        .wready    (wready),
        .w         (w),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .ar        (ar),
        .rvalid    (rvalid),
        .rready    (rready),
        .r         (r)
    );

    // ====================
    // response queue
    lsu_queue #(
        .DEPTH     (RSP_DEPTH),
        .payload_t (lsu_pkg::lsu_rsp_t)
    ) i_rsp_queue (
        .clk        (clk),
        .rst        (rst),
        .push_valid (mst_rsp_valid),
        .push_ready (rsp_push_ready),
        .push_data  (mst_rsp),
        .pop_valid  (rsp_valid),
        .pop_ready  (rsp_ready),
        .pop_data   (rsp)
    );

endmodule

// ==== tb/lsu_tb.sv ====
// Testbench for the load/store unit.
// Replays accesses from a trace file, answers them with an AXI4-Lite
// memory model with random ready delays, and checks every response in
// order against the trace while rsp_ready toggles at random.

module lsu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int trace_lines = 25;
    localparam int cols        = 7;

    logic                clk;
    logic                rst;
    logic                cmd_valid;
    logic                cmd_ready;
    lsu_pkg::lsu_cmd_t   cmd;
    logic                rsp_valid;
    logic                rsp_ready;
    lsu_pkg::lsu_rsp_t   rsp;
    logic                awvalid;
    logic                awready;
    logic                wvalid;
    logic                wready;
    logic                bvalid;
    logic                bready;
    logic                arvalid;
    logic                arready;
    logic                rvalid;
    logic                rready;
    lsu_pkg::axi_addr_t  aw;
    lsu_pkg::axi_addr_t  ar;
    lsu_pkg::axi_wdata_t w;
    lsu_pkg::axi_resp_e  bresp;
    lsu_pkg::axi_rdata_t r;

    logic [63:0] trace [trace_lines * cols];
    logic [63:0] mem [logic [31:0]];
    logic        aw_got;
    logic        w_got;
    logic [31:0] aw_addr;
    lsu_pkg::axi_wdata_t w_q;
    int          accept_cnt = 0;
    int          rsp_cnt = 0;
    int          errors = 0;

    lsu_top i_dut (
        .clk (clk), .rst (rst),
        .cmd_valid (cmd_valid), .cmd_ready (cmd_ready), .cmd (cmd),
        .rsp_valid (rsp_valid), .rsp_ready (rsp_ready), .rsp (rsp),
        .awvalid (awvalid), .awready (awready), .aw (aw),
        .wvalid (wvalid), .wready (wready), .w (w),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .ar (ar),
        .rvalid (rvalid), .rready (rready), .r (r)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // outside both the memory and the MMIO window
    function automatic logic unmapped_line(input int idx);
        logic [31:0] a;
        a = trace[idx * cols + 3][31:0];
        return !((a >= 32'h8000_0000 && a < 32'h8800_0000) ||
                 (a >= 32'h1000_0000 && a < 32'h2000_0000));
    endfunction

    function automatic lsu_pkg::lsu_cmd_t make_cmd(input int idx);
        lsu_pkg::lsu_cmd_t c;
        c.store       = trace[idx * cols][0];
        c.width       = lsu_pkg::mem_width_e'(trace[idx * cols + 1][1:0]);
        c.is_unsigned = trace[idx * cols + 2][0];
        c.addr        = trace[idx * cols + 3][31:0];
        c.wdata       = trace[idx * cols + 4];
        return c;
    endfunction

    // unwritten dwords read back a pattern of their own address
    function automatic logic [63:0] read_dword(input logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {~a, a};
    endfunction

    function automatic logic [63:0] merge_bytes(input logic [63:0] old,
                                                input lsu_pkg::axi_wdata_t wd);
        logic [63:0] res;
        res = old;
        for (int i = 0; i < 8; i++) begin
            if (wd.strb[i]) begin
                res[i*8 +: 8] = wd.data[i*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_idle(input string when);
        if (rsp_valid !== 1'b0 || awvalid !== 1'b0 || wvalid !== 1'b0 ||
            arvalid !== 1'b0 || bready !== 1'b0 || rready !== 1'b0 || cmd_ready !== 1'b1) begin
            $display("Mismatch at %0t: outputs not idle %s", $time, when);
            errors++;
        end
    endtask

    task automatic check_rsp(input int idx);
        logic        exp_store;
        logic        exp_err;
        logic [63:0] exp_data;
        logic        bad;
        exp_store = trace[idx * cols][0];
        exp_data  = trace[idx * cols + 5];
        exp_err   = trace[idx * cols + 6][0];
        bad       = 1'b0;
        if (rsp.store !== exp_store) begin
            $display("Mismatch at %0t: line %0d store flag %b, expected %b",
                     $time, idx + 1, rsp.store, exp_store);
            bad = 1'b1;
        end
        if (rsp.error !== exp_err) begin
            $display("Mismatch at %0t: line %0d error %b, expected %b",
                     $time, idx + 1, rsp.error, exp_err);
            bad = 1'b1;
        end
        if (rsp.data !== exp_data) begin
            $display("Mismatch at %0t: line %0d data %h, expected %h",
                     $time, idx + 1, rsp.data, exp_data);
            bad = 1'b1;
        end
        if (bad) begin
            errors++;
        end
        $display("line %0d %s %h: %s", idx + 1, exp_store ? "store" : "load ",
                 trace[idx * cols + 3][31:0], bad ? "failed" : "ok");
    endtask

    // ====================
    // random ready pattern for the slave model and the consumer
    initial begin
        void'($urandom(32'h73c7_07bf));
        forever begin
            @(posedge clk);
            if (rst) begin
                awready   <= 1'b0;
                wready    <= 1'b0;
                arready   <= 1'b0;
                rsp_ready <= 1'b0;
            end else begin
                awready   <= ($urandom % 3) != 0;
                wready    <= ($urandom % 3) != 0;
                arready   <= ($urandom % 3) != 0;
                rsp_ready <= ($urandom % 2) == 1;
            end
        end
    end

    // ====================
    // AXI4-Lite slave model
    always @(posedge clk) begin
        if (rst) begin
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                aw_got  <= 1'b1;
                aw_addr <= aw.addr;
                if (aw.prot !== 3'b000 || aw.addr[2:0] !== 3'b000) begin
                    $display("Mismatch at %0t: aw addr %h prot %b, expected aligned, prot 000",
                             $time, aw.addr, aw.prot);
                    errors++;
                end
            end
            if (wvalid && wready) begin
                w_got <= 1'b1;
                w_q   <= w;
            end
            if (aw_got && w_got && !bvalid) begin
                // error window swallows writes
                if (aw_addr >= 32'h1000_0000 && aw_addr <= 32'h1000_00ff) begin
                    bresp <= lsu_pkg::resp_slverr;
                end else begin
                    mem[aw_addr] = merge_bytes(read_dword(aw_addr), w_q);
                    bresp <= lsu_pkg::resp_okay;
                end
                bvalid <= 1'b1;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                if (ar.prot !== 3'b000 || ar.addr[2:0] !== 3'b000) begin
                    $display("Mismatch at %0t: ar addr %h prot %b, expected aligned, prot 000",
                             $time, ar.addr, ar.prot);
                    errors++;
                end
                r.data <= read_dword(ar.addr);
                r.resp <= (ar.addr >= 32'h1000_0000 && ar.addr <= 32'h1000_00ff) ?
                          lsu_pkg::resp_slverr : lsu_pkg::resp_okay;
                rvalid <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // ====================
    // response checker
    always @(posedge clk) begin
        if (!rst) begin
            if (accept_cnt - rsp_cnt == 1 && rsp_cnt < trace_lines && unmapped_line(rsp_cnt)
                && (awvalid || arvalid)) begin
                $display("bus request issued at %0t while unmapped line %0d was alone",
                         $time, rsp_cnt + 1);
                errors++;
            end
            if (cmd_valid && cmd_ready) begin
                accept_cnt <= accept_cnt + 1;
            end
            if (rsp_valid && rsp_ready) begin
                if (rsp_cnt >= trace_lines) begin
                    $display("response at %0t with no command outstanding", $time);
                    errors++;
                end else begin
                    check_rsp(rsp_cnt);
                end
                rsp_cnt <= rsp_cnt + 1;
            end
        end
    end

    // ====================
    // watchdog
    initial begin
        repeat (trace_lines * 200) @(posedge clk);
        $display("timeout: only %0d of %0d responses arrived", rsp_cnt, trace_lines);
        $display("TESTS FAILED");
        $finish;
    end

    // ====================
    // command driver
    initial begin
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        rsp_ready = 1'b0;
        awready   = 1'b0;
        wready    = 1'b0;
        arready   = 1'b0;
        bvalid    = 1'b0;
        rvalid    = 1'b0;
        bresp     = lsu_pkg::resp_okay;
        r         = '0;
        $readmemh("tb/lsu_trace.txt", trace);
        if ($isunknown(trace[trace_lines * cols - 1])) begin
            $display("trace file holds fewer than %0d lines", trace_lines);
            errors++;
        end
        @(posedge clk);
        repeat (2) begin
            @(posedge clk);
            check_idle("during reset");
        end
        rst <= 1'b0;
        @(posedge clk);
        check_idle("at reset release");
        @(posedge clk);
        check_idle("after reset");
        for (int i = 0; i < trace_lines; i++) begin
            // let an unmapped access run on its own
            if (unmapped_line(i)) begin
                cmd_valid <= 1'b0;
                @(posedge clk);
                while (accept_cnt != rsp_cnt) @(posedge clk);
            end
            cmd       <= make_cmd(i);
            cmd_valid <= 1'b1;
            @(posedge clk);
            while (!cmd_ready) @(posedge clk);
        end
        cmd_valid <= 1'b0;
        while (rsp_cnt < trace_lines) @(posedge clk);
        repeat (4) @(posedge clk);
        $display("%0d of %0d responses checked, %0d errors", rsp_cnt, trace_lines, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/lsu_trace.txt ====
// columns: store width(0 byte 1 half 2 word 3 dword) unsigned addr wdata
//          expected data, expected error
1 3 0 80000000 0123456789abcdef 0000000000000000 0
0 3 0 80000000 0000000000000000 0123456789abcdef 0
0 0 0 80000001 0000000000000000 ffffffffffffffcd 0
0 0 1 80000001 0000000000000000 00000000000000cd 0
0 1 0 80000002 0000000000000000 ffffffffffff89ab 0
0 1 1 80000006 0000000000000000 0000000000000123 0
0 2 0 80000000 0000000000000000 ffffffff89abcdef 0
0 2 1 80000004 0000000000000000 0000000001234567 0
1 0 0 80000005 00000000000000aa 0000000000000000 0
1 1 0 80000002 0000000000005a5a 0000000000000000 0
0 3 0 80000000 0000000000000000 0123aa675a5acdef 0
0 2 0 80000004 0000000000000000 000000000123aa67 0
1 2 0 80000104 00000000fedcba98 0000000000000000 0
0 2 0 80000104 0000000000000000 fffffffffedcba98 0
0 2 1 80000104 0000000000000000 00000000fedcba98 0
1 1 0 80000100 0000000000008001 0000000000000000 0
0 1 0 80000100 0000000000000000 ffffffffffff8001 0
1 0 0 80000103 000000000000007f 0000000000000000 0
0 0 0 80000103 0000000000000000 000000000000007f 0
1 3 0 10001000 1122334455667788 0000000000000000 0
0 0 1 10001006 0000000000000000 0000000000000022 0
1 2 0 10000010 00000000deadbeef 0000000000000000 1
0 3 0 10000008 0000000000000000 0000000000000000 1
0 2 0 00001000 0000000000000000 0000000000000000 1
1 0 0 90000000 0000000000000055 0000000000000000 1

// ==== list.f ====
common/lsu_pkg.sv
hdl/lsu_cmd_decode.sv
hdl/lsu_queue.sv
axi_master/lsu_axi_master.sv
hdl/lsu_top.sv
tb/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - common/lsu_pkg.sv
  - hdl/lsu_cmd_decode.sv
  - hdl/lsu_queue.sv
  - axi_master/lsu_axi_master.sv
  - hdl/lsu_top.sv
  - target: simulation
    files:
      - tb/lsu_tb.sv
